/* filelist.f */
+incdir+.
scu_dr_pkg.sv
scu_reg_pkg.sv
scu_scan_dr.sv
scu_access_ctrl.sv
scu_regs.sv
scu_rst_buf.sv
scu_rst_tree.sv
scu_top.sv
scu_checker.sv
scu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the system control unit testbench with Verilator and runs it.
# Exit status is 0 only when the run passed.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --top-module scu_tb -Mdir "$BUILD_DIR" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vscu_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test failed" "$LOG"; then
    exit 1
fi
if grep -q "%Error" "$LOG"; then
    echo "Simulator reported an error, see $LOG"
    exit 1
fi
if ! grep -qx "test passed" "$LOG"; then
    echo "No pass line found in $LOG"
    exit 1
fi
exit 0

/* scu_access_ctrl.sv */
// Operation decode for the system control registers
// Fully combinational, result valid in the update cycle
// Status is read only, sticky accepts only the clear-bits operation

`default_nettype none

module scu_access_ctrl (
    input  logic                        dr_update,
    input  scu_dr_pkg::sysctrl_op_e     dr_op,
    input  scu_dr_pkg::sysctrl_addr_e   dr_addr,
    input  scu_reg_pkg::sysctrl_word_u  dr_data,
    input  scu_reg_pkg::sysctrl_word_u  control_reg,
    input  scu_reg_pkg::sysctrl_word_u  mode_reg,
    input  scu_reg_pkg::sysctrl_word_u  status,
    input  scu_reg_pkg::sysctrl_word_u  sticky,
    output scu_reg_pkg::sysctrl_word_u  cmd_data,
    output logic                        control_wr,
    output logic                        mode_wr,
    output logic                        sticky_clr
);

    scu_reg_pkg::sysctrl_word_u reg_data;
    logic                       modify;

    // ========================================
    // Read mux
    // ========================================
    always_comb begin
        case (dr_addr)
            scu_dr_pkg::SCU_ADDR_CONTROL: reg_data = control_reg;
            scu_dr_pkg::SCU_ADDR_MODE:    reg_data = mode_reg;
            scu_dr_pkg::SCU_ADDR_STATUS:  reg_data = status;
            default:                      reg_data = sticky;
        endcase
    end

    // Result of the operation, also the new register value
    always_comb begin
        case (dr_op)
            scu_dr_pkg::SCU_OP_WRITE:   cmd_data.raw = dr_data.raw;
            scu_dr_pkg::SCU_OP_READ:    cmd_data.raw = reg_data.raw;
            scu_dr_pkg::SCU_OP_SETBITS: cmd_data.raw = reg_data.raw | dr_data.raw;
            default:                    cmd_data.raw = reg_data.raw & ~dr_data.raw;
        endcase
    end

    // ========================================
    // Write strobes
    // ========================================
    assign modify     = dr_update & (dr_op != scu_dr_pkg::SCU_OP_READ);

    assign control_wr = modify & (dr_addr == scu_dr_pkg::SCU_ADDR_CONTROL);
    assign mode_wr    = modify & (dr_addr == scu_dr_pkg::SCU_ADDR_MODE);
    // Sticky bits can only be cleared from the chain
    assign sticky_clr = modify & (dr_addr == scu_dr_pkg::SCU_ADDR_STICKY)
                               & (dr_op == scu_dr_pkg::SCU_OP_CLRBITS);

endmodule

`default_nettype wire

/* scu_checker.sv */
// Concurrent checks on the system control unit, bound into scu_top
// Takes the scan shift register and strobes from the u_scan_dr instance

`default_nettype none

`include "scu_config.svh"

module scu_checker (
    input logic                 clk,
    input logic                 pwrup_rst_n_sync,
    input logic                 dr_update,
    input logic                 dr_capture,
    input logic                 dr_shift,
    input logic                 tapc_ch_tdo,
    input logic [`SCU_DR_W-1:0] shift_reg,
    input logic                 sys_rst_n,
    input logic                 sys_rst_n_qlfy,
    input logic                 core_rst_n,
    input logic                 core_rst_n_qlfy
);

    // ========================================
    // Scan chain
    // ========================================
    update_pulse: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        dr_update |=> !dr_update)
        else $error("dr_update stayed high for more than one cycle");

    // Each shift brings the next bit of the chain out on TDO
    tdo_lsb: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        dr_shift && !dr_capture |=> tapc_ch_tdo == $past(shift_reg[1]))
        else $error("tapc_ch_tdo did not present the next shift register bit");

    // ========================================
    // Reset qualifiers
    // ========================================
    sys_qlfy_low: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        !sys_rst_n |-> !sys_rst_n_qlfy)
        else $error("sys_rst_n_qlfy high while sys_rst_n is asserted");

    core_qlfy_low: assert property (@(posedge clk) disable iff (!pwrup_rst_n_sync)
        !core_rst_n |-> !core_rst_n_qlfy)
        else $error("core_rst_n_qlfy high while core_rst_n is asserted");

endmodule

bind scu_top scu_checker u_checker (
    .clk              (clk),
    .pwrup_rst_n_sync (pwrup_rst_n_sync),
    .dr_update        (dr_update),
    .dr_capture       (u_scan_dr.dr_capture),
    .dr_shift         (u_scan_dr.dr_shift),
    .tapc_ch_tdo      (tapc_ch_tdo),
    .shift_reg        (u_scan_dr.shift_reg),
    .sys_rst_n        (sys_rst_n),
    .sys_rst_n_qlfy   (sys_rst_n_qlfy),
    .core_rst_n       (core_rst_n),
    .core_rst_n_qlfy  (core_rst_n_qlfy)
);

`default_nettype wire

/* scu_config.svh */
// Field widths and constants for the system control unit
// The scan word width must stay the sum of the three field widths
// Reset buffer depth below 2 is not supported

`ifndef SCU_CONFIG_SVH
`define SCU_CONFIG_SVH

// Scan word fields
`define SCU_OP_W            2
`define SCU_ADDR_W          2
`define SCU_DATA_W          4

`define SCU_DR_W            (`SCU_OP_W + `SCU_ADDR_W + `SCU_DATA_W)

// Chain id this unit answers to
`define SCU_CHAIN_ID        1'b0

// Register stages in each reset buffer
`define SCU_RST_BUF_DEPTH   2

`endif

/* scu_dr_pkg.sv */
// Scan access types for the system control chain
// Scan word is shifted LSB first, op sits in the low bits

`default_nettype none

package scu_dr_pkg;

`include "scu_config.svh"

    typedef enum logic [`SCU_OP_W-1:0] {
        SCU_OP_WRITE   = 2'h0,
        SCU_OP_READ    = 2'h1,
        SCU_OP_SETBITS = 2'h2,
        SCU_OP_CLRBITS = 2'h3
    } sysctrl_op_e;

    typedef enum logic [`SCU_ADDR_W-1:0] {
        SCU_ADDR_CONTROL = 2'h0,
        SCU_ADDR_MODE    = 2'h1,
        SCU_ADDR_STATUS  = 2'h2,
        SCU_ADDR_STICKY  = 2'h3
    } sysctrl_addr_e;

    typedef struct packed {
        logic [`SCU_DATA_W-1:0] data;   // Operand in, result out
        sysctrl_addr_e          addr;
        sysctrl_op_e            op;     // Shifted out first
    } sysctrl_dr_s;

endpackage

`default_nettype wire

/* scu_reg_pkg.sv */
// Register layouts behind the system control chain
// All registers are one 4-bit word, decoded by address

`default_nettype none

package scu_reg_pkg;

`include "scu_config.svh"

    typedef struct packed {
        logic [2:0] rsrv;           // Writable, no function
        logic       sys_reset;      // System reset request
    } control_reg_s;

    typedef struct packed {
        logic [1:0] rsrv;
        logic       hdu_rst_mux;    // 1: HDU reset from power-up only
        logic       dm_rst_mux;     // 1: DM reset follows system reset
    } mode_reg_s;

    // Also the sticky register layout
    typedef struct packed {
        logic hdu_reset;
        logic dm_reset;
        logic core_reset;
        logic sys_reset;
    } status_reg_s;

    typedef union packed {
        logic [`SCU_DATA_W-1:0] raw;
        control_reg_s           control;
        mode_reg_s              mode;
        status_reg_s            status;
    } sysctrl_word_u;

endpackage

`default_nettype wire

/* scu_regs.sv */
// Control, mode and sticky status registers
// Status input must be synchronous to clk
// Sticky set on a status rising edge wins over a clear in the same cycle

`default_nettype none

module scu_regs (
    input  logic                        clk,
    input  logic                        pwrup_rst_n_sync,
    input  scu_reg_pkg::sysctrl_word_u  cmd_data,
    input  logic                        control_wr,
    input  logic                        mode_wr,
    input  logic                        sticky_clr,
    input  scu_reg_pkg::status_reg_s    status,
    output scu_reg_pkg::sysctrl_word_u  control_reg,
    output scu_reg_pkg::sysctrl_word_u  mode_reg,
    output scu_reg_pkg::sysctrl_word_u  sticky,
    output logic                        sys_reset_req,
    output logic                        dm_rst_mux,
    output logic                        hdu_rst_mux
);

    scu_reg_pkg::status_reg_s status_dly;
    scu_reg_pkg::status_reg_s status_rise;

    // ========================================
    // Control and mode
    // ========================================
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            control_reg <= '0;
        end else if (control_wr) begin
            control_reg <= cmd_data;
        end
    end

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            mode_reg <= '0;
        end else if (mode_wr) begin
            mode_reg <= cmd_data;
        end
    end

    assign sys_reset_req = control_reg.control.sys_reset;
    assign dm_rst_mux    = mode_reg.mode.dm_rst_mux;
    assign hdu_rst_mux   = mode_reg.mode.hdu_rst_mux;

    // ========================================
    // Sticky status
    // ========================================
    // Zero after power-up, so every sticky bit sets once
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            status_dly <= '0;
        end else begin
            status_dly <= status;
        end
    end

    assign status_rise = status & ~status_dly;

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            sticky <= '0;
        end else begin
            for (int i = 0; i < $bits(scu_reg_pkg::status_reg_s); i++) begin
                if (status_rise[i]) begin
                    sticky.raw[i] <= 1'b1;
                end else if (sticky_clr) begin
                    sticky.raw[i] <= cmd_data.raw[i];   // Already R & ~D
                end
            end
        end
    end

endmodule

`default_nettype wire

/* scu_rst_buf.sv */
// Registered reset buffer with qualifier
// rst_in_n must be synchronous to clk, src_rst_n clears all stages at once
// Qualifier leads the reset by one cycle on assert, trails it on release

`default_nettype none

`include "scu_config.svh"

module scu_rst_buf (
    input  logic clk,
    input  logic src_rst_n,
    input  logic rst_in_n,
    output logic rst_out_n,
    output logic rst_qlfy_n,
    output logic rst_status_n
);

    logic [`SCU_RST_BUF_DEPTH-1:0] stage;
    logic                          qlfy_dly;

    always_ff @(posedge clk or negedge src_rst_n) begin
        if (!src_rst_n) begin
            stage    <= '0;
            qlfy_dly <= 1'b0;
        end else begin
            stage    <= {stage[`SCU_RST_BUF_DEPTH-2:0], rst_in_n};
            qlfy_dly <= stage[`SCU_RST_BUF_DEPTH-1];   // Holds qualifier off one more cycle
        end
    end

    assign rst_out_n    = stage[`SCU_RST_BUF_DEPTH-1];
    assign rst_qlfy_n   = stage[0] & qlfy_dly;  // Drops with the first stage
    assign rst_status_n = rst_out_n & rst_qlfy_n;

endmodule

`default_nettype wire

/* scu_rst_tree.sv */
// Reset generation for system, core, debug module and hart debug unit
// All reset inputs are taken as synchronous to clk
// DM and HDU buffers have no qualifier on the pins

`default_nettype none

module scu_rst_tree (
    input  logic                        clk,
    input  logic                        pwrup_rst_n_sync,
    input  logic                        rst_n,
    input  logic                        cpu_rst_n,
    input  logic                        ndm_rst_n,
    input  logic                        hart_rst_n,
    input  logic                        sys_reset_req,
    input  logic                        dm_rst_mux,
    input  logic                        hdu_rst_mux,
    output logic                        sys_rst_n,
    output logic                        sys_rst_n_qlfy,
    output logic                        core_rst_n,
    output logic                        core_rst_n_qlfy,
    output logic                        dm_rst_n,
    output logic                        hdu_rst_n,
    output scu_reg_pkg::status_reg_s    status
);

    logic sys_in_n;
    logic sys_status_n;
    logic core_in_n;
    logic core_buf_qlfy_n;
    logic core_status_n;
    logic dm_src_n;
    logic dm_status_n;
    logic hdu_src_n;
    logic hdu_status_n;

    // ========================================
    // System reset
    // ========================================
    assign sys_in_n = rst_n & ~sys_reset_req;

    scu_rst_buf u_sys_buf (
        .clk          (clk),
        .src_rst_n    (pwrup_rst_n_sync),
        .rst_in_n     (sys_in_n),
        .rst_out_n    (sys_rst_n),
        .rst_qlfy_n   (sys_rst_n_qlfy),
        .rst_status_n (sys_status_n)
    );

    // Core reset, any of CPU, non-DM or hart request
    assign core_in_n = cpu_rst_n & ndm_rst_n & hart_rst_n;

    scu_rst_buf u_core_buf (
        .clk          (clk),
        .src_rst_n    (sys_rst_n),
        .rst_in_n     (core_in_n),
        .rst_out_n    (core_rst_n),
        .rst_qlfy_n   (core_buf_qlfy_n),
        .rst_status_n (core_status_n)
    );

    assign core_rst_n_qlfy = core_buf_qlfy_n & sys_rst_n_qlfy;  // Also drops ahead of sys reset

    // ========================================
    // Debug resets
    // ========================================
    assign dm_src_n  = dm_rst_mux ? sys_rst_n : pwrup_rst_n_sync;
    assign hdu_src_n = hdu_rst_mux ? pwrup_rst_n_sync : core_rst_n;

    scu_rst_buf u_dm_buf (
        .clk          (clk),
        .src_rst_n    (dm_src_n),
        .rst_in_n     (1'b1),
        .rst_out_n    (dm_rst_n),
        .rst_qlfy_n   (),
        .rst_status_n (dm_status_n)
    );

    scu_rst_buf u_hdu_buf (
        .clk          (clk),
        .src_rst_n    (hdu_src_n),
        .rst_in_n     (1'b1),
        .rst_out_n    (hdu_rst_n),
        .rst_qlfy_n   (),
        .rst_status_n (hdu_status_n)
    );

    assign status.sys_reset  = ~sys_status_n;
    assign status.core_reset = ~(core_status_n & sys_rst_n_qlfy);
    assign status.dm_reset   = ~dm_status_n;
    assign status.hdu_reset  = ~hdu_status_n;

endmodule

`default_nettype wire

/* scu_scan_dr.sv */
// JTAG data register for the system control chain
// Capture, shift and update are single-cycle strobes in the clk domain
// Only chain id SCU_CHAIN_ID is decoded, others are ignored

`default_nettype none

`include "scu_config.svh"

module scu_scan_dr (
    input  logic                        clk,
    input  logic                        pwrup_rst_n_sync,
    input  logic                        tapc_ch_sel,
    input  logic                        tapc_ch_id,
    input  logic                        tapc_ch_capture,
    input  logic                        tapc_ch_shift,
    input  logic                        tapc_ch_update,
    input  logic                        tapc_ch_tdi,
    input  scu_reg_pkg::sysctrl_word_u  cmd_data,
    output logic                        tapc_ch_tdo,
    output logic                        dr_update,
    output scu_dr_pkg::sysctrl_op_e     dr_op,
    output scu_dr_pkg::sysctrl_addr_e   dr_addr,
    output scu_reg_pkg::sysctrl_word_u  dr_data
);

    scu_dr_pkg::sysctrl_dr_s shift_reg;
    scu_dr_pkg::sysctrl_dr_s shadow_reg;
    logic                    chain_hit;
    logic                    dr_capture;
    logic                    dr_shift;

    // ========================================
    // Chain strobe decode
    // ========================================
    assign chain_hit  = tapc_ch_sel & (tapc_ch_id == `SCU_CHAIN_ID);
    assign dr_capture = chain_hit & tapc_ch_capture;
    assign dr_shift   = chain_hit & tapc_ch_shift;
    assign dr_update  = chain_hit & tapc_ch_update;

    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shift_reg <= '0;
        end else if (dr_capture) begin
            shift_reg <= shadow_reg;    // Last result goes out
        end else if (dr_shift) begin
            shift_reg <= {tapc_ch_tdi, shift_reg[`SCU_DR_W-1:1]};
        end
    end

    // Shadow keeps the request, data replaced by the result
    always_ff @(posedge clk or negedge pwrup_rst_n_sync) begin
        if (!pwrup_rst_n_sync) begin
            shadow_reg <= '0;
        end else if (dr_update) begin
            shadow_reg.op   <= shift_reg.op;
            shadow_reg.addr <= shift_reg.addr;
            shadow_reg.data <= cmd_data.raw;
        end
    end

    assign dr_op       = shift_reg.op;
    assign dr_addr     = shift_reg.addr;
    assign dr_data     = shift_reg.data;
    assign tapc_ch_tdo = shift_reg[0];  // LSB first

endmodule

`default_nettype wire

/* scu_tb.sv */
// Testbench for scu_top over the system control scan chain
// Inputs change on the falling clock edge and outputs are checked there too
// Readback takes two read scans, the second one shifts out the register value

`default_nettype none

`include "scu_config.svh"

module scu_tb;

    localparam int          RST_CYCLES  = 10;
    localparam int          RELEASE_CYC = 20;   // Reset tree release chain
    localparam int          SETTLE_CYC  = 4;
    localparam int          ROW_BUDGET  = 200;  // Watchdog cycles per row
    localparam logic [31:0] LFSR_SEED   = 32'd83486;
    localparam logic [31:0] LFSR_TAPS   = 32'hD000_0001;

    // Short names for the table
    localparam scu_dr_pkg::sysctrl_op_e   OP_WR  = scu_dr_pkg::SCU_OP_WRITE;
    localparam scu_dr_pkg::sysctrl_op_e   OP_RD  = scu_dr_pkg::SCU_OP_READ;
    localparam scu_dr_pkg::sysctrl_op_e   OP_SET = scu_dr_pkg::SCU_OP_SETBITS;
    localparam scu_dr_pkg::sysctrl_op_e   OP_CLR = scu_dr_pkg::SCU_OP_CLRBITS;
    localparam scu_dr_pkg::sysctrl_addr_e A_CTRL = scu_dr_pkg::SCU_ADDR_CONTROL;
    localparam scu_dr_pkg::sysctrl_addr_e A_MODE = scu_dr_pkg::SCU_ADDR_MODE;
    localparam scu_dr_pkg::sysctrl_addr_e A_STAT = scu_dr_pkg::SCU_ADDR_STATUS;
    localparam scu_dr_pkg::sysctrl_addr_e A_STKY = scu_dr_pkg::SCU_ADDR_STICKY;

    typedef struct packed {
        logic                      chain_id;
        logic                      hart_n;     // hart_rst_n during the row
        scu_dr_pkg::sysctrl_op_e   op;
        scu_dr_pkg::sysctrl_addr_e addr;
        logic                      rnd;        // LFSR data, readback expects it
        logic [`SCU_DATA_W-1:0]    data;
        logic [3:0]                rst_exp;    // {sys, core, dm, hdu}
        logic [`SCU_DATA_W-1:0]    rd_exp;
    } row_s;

    logic clk;
    logic pwrup_rst_n_sync;
    logic rst_n;
    logic cpu_rst_n;
    logic ndm_rst_n;
    logic hart_rst_n;
    logic tapc_ch_sel;
    logic tapc_ch_id;
    logic tapc_ch_capture;
    logic tapc_ch_shift;
    logic tapc_ch_update;
    logic tapc_ch_tdi;
    logic tapc_ch_tdo;
    logic sys_rst_n;
    logic sys_rst_n_qlfy;
    logic core_rst_n;
    logic core_rst_n_qlfy;
    logic dm_rst_n;
    logic hdu_rst_n;

    row_s        rows[$];
    logic [31:0] lfsr_state;
    logic        table_ready;
    int          errors;
    int          checks;

    scu_top u_dut (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n            (rst_n),
        .cpu_rst_n        (cpu_rst_n),
        .ndm_rst_n        (ndm_rst_n),
        .hart_rst_n       (hart_rst_n),
        .tapc_ch_sel      (tapc_ch_sel),
        .tapc_ch_id       (tapc_ch_id),
        .tapc_ch_capture  (tapc_ch_capture),
        .tapc_ch_shift    (tapc_ch_shift),
        .tapc_ch_update   (tapc_ch_update),
        .tapc_ch_tdi      (tapc_ch_tdi),
        .tapc_ch_tdo      (tapc_ch_tdo),
        .sys_rst_n        (sys_rst_n),
        .sys_rst_n_qlfy   (sys_rst_n_qlfy),
        .core_rst_n       (core_rst_n),
        .core_rst_n_qlfy  (core_rst_n_qlfy),
        .dm_rst_n         (dm_rst_n),
        .hdu_rst_n        (hdu_rst_n)
    );

    always #5 clk = ~clk;   // Period 10

    // ========================================
    // Stimulus helpers
    // ========================================
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    task automatic draw_nibble(output logic [`SCU_DATA_W-1:0] value);
        for (int i = 0; i < `SCU_DATA_W; i++) begin
            value[i]   = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);    // One step per bit
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Capture, 8 shifts and update on the chain, returns what came out of TDO
    task automatic scan_dr(input logic id, input logic [`SCU_DR_W-1:0] word_in,
                           output logic [`SCU_DR_W-1:0] word_out);
        word_out = '0;
        @(negedge clk);
        tapc_ch_sel     = 1'b1;
        tapc_ch_id      = id;
        tapc_ch_capture = 1'b1;
        for (int i = 0; i < `SCU_DR_W; i++) begin
            @(negedge clk);
            tapc_ch_capture = 1'b0;
            word_out[i]     = tapc_ch_tdo;          // TDO before the shift edge
            tapc_ch_shift   = 1'b1;
            tapc_ch_tdi     = word_in[i];
        end
        @(negedge clk);
        tapc_ch_shift  = 1'b0;
        tapc_ch_tdi    = 1'b0;
        tapc_ch_update = 1'b1;
        @(negedge clk);
        tapc_ch_update = 1'b0;
        tapc_ch_sel    = 1'b0;
        tapc_ch_id     = 1'b0;
    endtask

    // ========================================
    // Compare tasks
    // ========================================
    task automatic compare_word(input string name, input scu_reg_pkg::sysctrl_word_u got,
                                input scu_reg_pkg::sysctrl_word_u exp);
        checks++;
        if (got.raw !== exp.raw) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
        end
    endtask

    task automatic compare_status(input string name, input scu_reg_pkg::status_reg_s got,
                                  input scu_reg_pkg::status_reg_s exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ========================================
    // Table
    // ========================================
    task automatic add_row(input logic id, input logic hart_n,
                           input scu_dr_pkg::sysctrl_op_e op,
                           input scu_dr_pkg::sysctrl_addr_e addr, input logic rnd,
                           input logic [3:0] data, input logic [3:0] rst_exp,
                           input logic [3:0] rd_exp);
        row_s r;
        r.chain_id = id;
        r.hart_n   = hart_n;
        r.op       = op;
        r.addr     = addr;
        r.rnd      = rnd;
        r.data     = data;
        r.rst_exp  = rst_exp;
        r.rd_exp   = rd_exp;
        rows.push_back(r);
    endtask

    task automatic load_table();
        // id    hart  op      addr    rnd   data  resets readback
        add_row(1'b0, 1'b1, OP_RD,  A_CTRL, 1'b0, 4'h0, 4'hF, 4'h0);   // After power-up
        add_row(1'b0, 1'b1, OP_RD,  A_MODE, 1'b0, 4'h0, 4'hF, 4'h0);
        add_row(1'b0, 1'b1, OP_RD,  A_STAT, 1'b0, 4'h0, 4'hF, 4'h0);
        add_row(1'b0, 1'b1, OP_RD,  A_STKY, 1'b0, 4'h0, 4'hF, 4'hF);
        add_row(1'b0, 1'b1, OP_WR,  A_CTRL, 1'b0, 4'hE, 4'hF, 4'hE);   // Reserved bits only
        add_row(1'b0, 1'b1, OP_CLR, A_CTRL, 1'b0, 4'h6, 4'hF, 4'h8);
        add_row(1'b0, 1'b1, OP_SET, A_CTRL, 1'b0, 4'h4, 4'hF, 4'hC);
        add_row(1'b0, 1'b1, OP_CLR, A_CTRL, 1'b0, 4'hC, 4'hF, 4'h0);
        add_row(1'b0, 1'b1, OP_WR,  A_MODE, 1'b1, 4'h0, 4'hF, 4'h0);
        add_row(1'b0, 1'b1, OP_WR,  A_MODE, 1'b0, 4'hC, 4'hF, 4'hC);
        add_row(1'b0, 1'b1, OP_CLR, A_MODE, 1'b0, 4'h4, 4'hF, 4'h8);
        add_row(1'b0, 1'b1, OP_WR,  A_STAT, 1'b0, 4'hF, 4'hF, 4'h0);   // Read only
        add_row(1'b0, 1'b1, OP_SET, A_STAT, 1'b0, 4'hF, 4'hF, 4'h0);
        add_row(1'b0, 1'b1, OP_WR,  A_STKY, 1'b0, 4'h0, 4'hF, 4'hF);
        add_row(1'b0, 1'b1, OP_CLR, A_STKY, 1'b0, 4'hF, 4'hF, 4'h0);
        add_row(1'b0, 1'b1, OP_WR,  A_CTRL, 1'b0, 4'h1, 4'h2, 4'h1);   // System reset request
        add_row(1'b0, 1'b1, OP_RD,  A_STAT, 1'b0, 4'h0, 4'h2, 4'hB);
        add_row(1'b0, 1'b1, OP_RD,  A_STKY, 1'b0, 4'h0, 4'h2, 4'hB);
        add_row(1'b0, 1'b1, OP_CLR, A_STKY, 1'b0, 4'hF, 4'h2, 4'h0);
        add_row(1'b0, 1'b1, OP_SET, A_MODE, 1'b0, 4'h1, 4'h0, 4'h9);   // DM follows system
        add_row(1'b0, 1'b1, OP_RD,  A_STKY, 1'b0, 4'h0, 4'h0, 4'h4);
        add_row(1'b0, 1'b1, OP_RD,  A_STAT, 1'b0, 4'h0, 4'h0, 4'hF);
        add_row(1'b0, 1'b1, OP_WR,  A_CTRL, 1'b0, 4'h0, 4'hF, 4'h0);
        add_row(1'b0, 1'b1, OP_CLR, A_STKY, 1'b0, 4'hF, 4'hF, 4'h0);
        add_row(1'b0, 1'b0, OP_RD,  A_STAT, 1'b0, 4'h0, 4'hA, 4'hA);   // Hart reset
        add_row(1'b0, 1'b0, OP_RD,  A_STKY, 1'b0, 4'h0, 4'hA, 4'hA);
        add_row(1'b0, 1'b0, OP_SET, A_MODE, 1'b0, 4'h2, 4'hB, 4'hB);   // HDU on power-up only
        add_row(1'b0, 1'b1, OP_RD,  A_STAT, 1'b0, 4'h0, 4'hF, 4'h0);
        add_row(1'b0, 1'b0, OP_RD,  A_STAT, 1'b0, 4'h0, 4'hB, 4'h2);
        add_row(1'b0, 1'b1, OP_WR,  A_MODE, 1'b0, 4'h0, 4'hF, 4'h0);
        add_row(1'b1, 1'b1, OP_WR,  A_CTRL, 1'b0, 4'hF, 4'hF, 4'h0);   // Other chain id
        add_row(1'b1, 1'b1, OP_WR,  A_MODE, 1'b0, 4'hF, 4'hF, 4'h0);
        add_row(1'b1, 1'b1, OP_CLR, A_STKY, 1'b0, 4'hF, 4'hF, 4'hA);
        add_row(1'b0, 1'b1, OP_WR,  A_MODE, 1'b1, 4'h0, 4'hF, 4'h0);
    endtask

    task automatic run_row(input int idx, input row_s r);
        scu_dr_pkg::sysctrl_dr_s    cmd;
        scu_dr_pkg::sysctrl_dr_s    rd_cmd;
        scu_dr_pkg::sysctrl_dr_s    out_word;
        scu_reg_pkg::sysctrl_word_u got_word;
        scu_reg_pkg::sysctrl_word_u exp_word;
        logic [`SCU_DATA_W-1:0]     data;
        logic [`SCU_DR_W-1:0]       shifted;
        data = r.data;
        if (r.rnd) begin
            draw_nibble(data);
        end
        hart_rst_n  = r.hart_n;
        cmd.op      = r.op;
        cmd.addr    = r.addr;
        cmd.data    = data;
        rd_cmd.op   = OP_RD;
        rd_cmd.addr = r.addr;
        rd_cmd.data = '0;
        scan_dr(r.chain_id, cmd, shifted);
        wait_cycles(SETTLE_CYC);
        scan_dr(1'b0, rd_cmd, shifted);
        scan_dr(1'b0, rd_cmd, shifted);     // Shifts out the value read above
        out_word     = shifted;
        got_word.raw = out_word.data;
        exp_word.raw = r.rnd ? data : r.rd_exp;
        if (r.addr == A_STAT || r.addr == A_STKY) begin
            compare_status($sformatf("row %0d readback", idx), got_word.status,
                           exp_word.status);
        end else begin
            compare_word($sformatf("row %0d readback", idx), got_word, exp_word);
        end
        // Steady state, so each qualifier matches its reset
        compare_bit($sformatf("row %0d sys_rst_n", idx), sys_rst_n, r.rst_exp[3]);
        compare_bit($sformatf("row %0d sys_rst_n_qlfy", idx), sys_rst_n_qlfy, r.rst_exp[3]);
        compare_bit($sformatf("row %0d core_rst_n", idx), core_rst_n, r.rst_exp[2]);
        compare_bit($sformatf("row %0d core_rst_n_qlfy", idx), core_rst_n_qlfy, r.rst_exp[2]);
        compare_bit($sformatf("row %0d dm_rst_n", idx), dm_rst_n, r.rst_exp[1]);
        compare_bit($sformatf("row %0d hdu_rst_n", idx), hdu_rst_n, r.rst_exp[0]);
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        clk              = 1'b0;
        pwrup_rst_n_sync = 1'b0;
        rst_n            = 1'b1;
        cpu_rst_n        = 1'b1;
        ndm_rst_n        = 1'b1;
        hart_rst_n       = 1'b1;
        tapc_ch_sel      = 1'b0;
        tapc_ch_id       = 1'b0;
        tapc_ch_capture  = 1'b0;
        tapc_ch_shift    = 1'b0;
        tapc_ch_update   = 1'b0;
        tapc_ch_tdi      = 1'b0;
        errors           = 0;
        checks           = 0;
        lfsr_state       = LFSR_SEED;
        table_ready      = 1'b0;
        load_table();
        table_ready = 1'b1;
        wait_cycles(RST_CYCLES);
        pwrup_rst_n_sync = 1'b1;
        wait_cycles(RELEASE_CYC);
        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end
        wait_cycles(2);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        int limit;
        wait (table_ready === 1'b1);
        limit = RST_CYCLES + RELEASE_CYC + ROW_BUDGET * rows.size();
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the table did not finish", limit);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* scu_top.sv */
// System control unit top level
// All reset inputs must be synchronous to clk
// Register access only through chain id 0

`default_nettype none

module scu_top (
    input  logic clk,
    input  logic pwrup_rst_n_sync,
    input  logic rst_n,
    input  logic cpu_rst_n,
    input  logic ndm_rst_n,
    input  logic hart_rst_n,
    // JTAG chain
    input  logic tapc_ch_sel,
    input  logic tapc_ch_id,
    input  logic tapc_ch_capture,
    input  logic tapc_ch_shift,
    input  logic tapc_ch_update,
    input  logic tapc_ch_tdi,
    output logic tapc_ch_tdo,
    // Generated resets
    output logic sys_rst_n,
    output logic sys_rst_n_qlfy,
    output logic core_rst_n,
    output logic core_rst_n_qlfy,
    output logic dm_rst_n,
    output logic hdu_rst_n
);

    logic                       dr_update;
    scu_dr_pkg::sysctrl_op_e    dr_op;
    scu_dr_pkg::sysctrl_addr_e  dr_addr;
    scu_reg_pkg::sysctrl_word_u dr_data;
    scu_reg_pkg::sysctrl_word_u cmd_data;
    logic                       control_wr;
    logic                       mode_wr;
    logic                       sticky_clr;
    scu_reg_pkg::sysctrl_word_u control_reg;
    scu_reg_pkg::sysctrl_word_u mode_reg;
    scu_reg_pkg::sysctrl_word_u sticky;
    scu_reg_pkg::status_reg_s   status;
    logic                       sys_reset_req;
    logic                       dm_rst_mux;
    logic                       hdu_rst_mux;

    scu_scan_dr u_scan_dr (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .tapc_ch_sel      (tapc_ch_sel),
        .tapc_ch_id       (tapc_ch_id),
        .tapc_ch_capture  (tapc_ch_capture),
        .tapc_ch_shift    (tapc_ch_shift),
        .tapc_ch_update   (tapc_ch_update),
        .tapc_ch_tdi      (tapc_ch_tdi),
        .cmd_data         (cmd_data),
        .tapc_ch_tdo      (tapc_ch_tdo),
        .dr_update        (dr_update),
        .dr_op            (dr_op),
        .dr_addr          (dr_addr),
        .dr_data          (dr_data)
    );

    scu_access_ctrl u_access_ctrl (
        .dr_update   (dr_update),
        .dr_op       (dr_op),
        .dr_addr     (dr_addr),
        .dr_data     (dr_data),
        .control_reg (control_reg),
        .mode_reg    (mode_reg),
        .status      (status),      // Status layout read as a raw word
        .sticky      (sticky),
        .cmd_data    (cmd_data),
        .control_wr  (control_wr),
        .mode_wr     (mode_wr),
        .sticky_clr  (sticky_clr)
    );

    scu_regs u_regs (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .cmd_data         (cmd_data),
        .control_wr       (control_wr),
        .mode_wr          (mode_wr),
        .sticky_clr       (sticky_clr),
        .status           (status),
        .control_reg      (control_reg),
        .mode_reg         (mode_reg),
        .sticky           (sticky),
        .sys_reset_req    (sys_reset_req),
        .dm_rst_mux       (dm_rst_mux),
        .hdu_rst_mux      (hdu_rst_mux)
    );

    scu_rst_tree u_rst_tree (
        .clk              (clk),
        .pwrup_rst_n_sync (pwrup_rst_n_sync),
        .rst_n            (rst_n),
        .cpu_rst_n        (cpu_rst_n),
        .ndm_rst_n        (ndm_rst_n),
        .hart_rst_n       (hart_rst_n),
        .sys_reset_req    (sys_reset_req),
        .dm_rst_mux       (dm_rst_mux),
        .hdu_rst_mux      (hdu_rst_mux),
        .sys_rst_n        (sys_rst_n),
        .sys_rst_n_qlfy   (sys_rst_n_qlfy),
        .core_rst_n       (core_rst_n),
        .core_rst_n_qlfy  (core_rst_n_qlfy),
        .dm_rst_n         (dm_rst_n),
        .hdu_rst_n        (hdu_rst_n),
        .status           (status)
    );

endmodule

`default_nettype wire
